// ==== riscv_csr_pkg.sv ====
package riscv_csr_pkg;

  localparam int XLEN = 32;

  typedef logic [XLEN-1:0] xlen_t;   // Data word
  typedef logic [31:0]     instr_t;  // Instruction word
  typedef logic [11:0]     csr_addr_t;

  // CSR access kind after decode
  typedef enum logic [1:0] {
    CSR_OP_NONE,
    CSR_OP_WRITE,
    CSR_OP_SET,
    CSR_OP_CLEAR
  } csr_op_t;

  // Machine CSR addresses
  localparam csr_addr_t CSR_MSTATUS  = 12'h300;
  localparam csr_addr_t CSR_MIE      = 12'h304;
  localparam csr_addr_t CSR_MTVEC    = 12'h305;
  localparam csr_addr_t CSR_MSCRATCH = 12'h340;
  localparam csr_addr_t CSR_MEPC     = 12'h341;
  localparam csr_addr_t CSR_MCAUSE   = 12'h342;
  localparam csr_addr_t CSR_MTVAL    = 12'h343;
  localparam csr_addr_t CSR_MIP      = 12'h344;

  localparam xlen_t CAUSE_ILLEGAL_INSTR = 32'h0000_0002;
  localparam xlen_t CAUSE_M_TIMER_INT   = 32'h8000_0007;  // Interrupt bit set

  localparam int MSTATUS_MIE_BIT  = 3;
  localparam int MSTATUS_MPIE_BIT = 7;
  localparam int MIE_MTIE_BIT     = 7;
  localparam int MIP_MTIP_BIT     = 7;

  // SYSTEM encoding fields
  localparam logic [6:0]  OPCODE_SYSTEM = 7'b111_0011;
  localparam logic [11:0] FUNCT12_MRET  = 12'h302;
  localparam logic [2:0]  F3_PRIV   = 3'b000;  // ecall, ebreak, mret, wfi
  localparam logic [2:0]  F3_CSRRW  = 3'b001;
  localparam logic [2:0]  F3_CSRRS  = 3'b010;
  localparam logic [2:0]  F3_CSRRC  = 3'b011;
  localparam logic [2:0]  F3_CSRRWI = 3'b101;
  localparam logic [2:0]  F3_CSRRSI = 3'b110;
  localparam logic [2:0]  F3_CSRRCI = 3'b111;

endpackage

// ==== csr_platform_pkg.sv ====
package csr_platform_pkg;

  typedef logic [63:0] timer_t;     // mtime and mtimecmp width
  typedef logic [31:0] tmr_addr_t;  // Timer bus address

  // Timer memory map
  localparam tmr_addr_t MTIME_ADDR_LO    = 32'h0200_BFF8;
  localparam tmr_addr_t MTIME_ADDR_HI    = 32'h0200_BFFC;
  localparam tmr_addr_t MTIMECMP_ADDR_LO = 32'h0200_4000;
  localparam tmr_addr_t MTIMECMP_ADDR_HI = 32'h0200_4004;

  // Trap vector out of reset
  localparam riscv_csr_pkg::xlen_t RESET_MTVEC = 32'h0000_0100;

  // Writable bits per CSR
  localparam riscv_csr_pkg::xlen_t MSTATUS_WMASK =
    (riscv_csr_pkg::xlen_t'(1) << riscv_csr_pkg::MSTATUS_MIE_BIT) |
    (riscv_csr_pkg::xlen_t'(1) << riscv_csr_pkg::MSTATUS_MPIE_BIT);

  localparam riscv_csr_pkg::xlen_t MIE_WMASK =
    riscv_csr_pkg::xlen_t'(1) << riscv_csr_pkg::MIE_MTIE_BIT;  // Timer only

  localparam riscv_csr_pkg::xlen_t MIP_WMASK =
    riscv_csr_pkg::xlen_t'(1) << riscv_csr_pkg::MIP_MTIP_BIT;  // Lets SW clear MTIP

endpackage

// ==== csr_decode.sv ====
`timescale 1ns/10ps

module csr_decode (
  input  riscv_csr_pkg::instr_t    instr_i,
  input  logic                     instr_valid_i,
  input  riscv_csr_pkg::xlen_t     rs1_data_i,
  output logic                     csr_en_o,
  output logic                     csr_we_o,
  output logic                     mret_o,
  output logic                     illegal_o,
  output riscv_csr_pkg::csr_op_t   csr_op_o,
  output riscv_csr_pkg::csr_addr_t csr_addr_o,
  output riscv_csr_pkg::xlen_t     csr_wdata_o
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [4:0] rs1_field;   // Doubles as zimm
  logic [4:0] rd_field;
  logic       is_system;   // Valid SYSTEM opcode
  logic       addr_ok;     // Address is one of ours
  riscv_csr_pkg::csr_op_t op;

  assign opcode    = instr_i[6:0];
  assign rd_field  = instr_i[11:7];
  assign funct3    = instr_i[14:12];
  assign rs1_field = instr_i[19:15];
  assign is_system = instr_valid_i && (opcode == riscv_csr_pkg::OPCODE_SYSTEM);

  assign csr_addr_o = instr_i[31:20];

  // Implemented CSR check
  always_comb begin : addr_check
    case (csr_addr_o)
      riscv_csr_pkg::CSR_MSTATUS, riscv_csr_pkg::CSR_MIE,
      riscv_csr_pkg::CSR_MTVEC, riscv_csr_pkg::CSR_MSCRATCH,
      riscv_csr_pkg::CSR_MEPC, riscv_csr_pkg::CSR_MCAUSE,
      riscv_csr_pkg::CSR_MTVAL, riscv_csr_pkg::CSR_MIP: addr_ok = 1'b1;
      default:                                          addr_ok = 1'b0;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // funct3 split
  ////////////////////////////////////////////////////////////////////////////
  always_comb begin : op_decode
    op          = riscv_csr_pkg::CSR_OP_NONE;
    csr_wdata_o = rs1_data_i;               // Register forms
    mret_o      = 1'b0;
    illegal_o   = 1'b0;
    if (is_system) begin
      case (funct3)
        riscv_csr_pkg::F3_PRIV: begin
          // Only MRET handled here, ecall comes from another stage
          mret_o = (csr_addr_o == riscv_csr_pkg::FUNCT12_MRET) &&
                   (rs1_field == 5'd0) && (rd_field == 5'd0);
        end
        riscv_csr_pkg::F3_CSRRW: op = riscv_csr_pkg::CSR_OP_WRITE;
        riscv_csr_pkg::F3_CSRRS: op = riscv_csr_pkg::CSR_OP_SET;
        riscv_csr_pkg::F3_CSRRC: op = riscv_csr_pkg::CSR_OP_CLEAR;
        riscv_csr_pkg::F3_CSRRWI: begin
          op          = riscv_csr_pkg::CSR_OP_WRITE;
          csr_wdata_o = riscv_csr_pkg::xlen_t'(rs1_field);  // Zero extended
        end
        riscv_csr_pkg::F3_CSRRSI: begin
          op          = riscv_csr_pkg::CSR_OP_SET;
          csr_wdata_o = riscv_csr_pkg::xlen_t'(rs1_field);
        end
        riscv_csr_pkg::F3_CSRRCI: begin
          op          = riscv_csr_pkg::CSR_OP_CLEAR;
          csr_wdata_o = riscv_csr_pkg::xlen_t'(rs1_field);
        end
        default: illegal_o = 1'b1;          // funct3 100
      endcase
      // Unknown CSR kills the access
      if ((op != riscv_csr_pkg::CSR_OP_NONE) && !addr_ok) begin
        illegal_o = 1'b1;
        op        = riscv_csr_pkg::CSR_OP_NONE;
      end
    end
  end

  assign csr_op_o = op;
  assign csr_en_o = (op != riscv_csr_pkg::CSR_OP_NONE);

  // Set or clear with a zero source never writes
  assign csr_we_o = csr_en_o &&
                    ((op == riscv_csr_pkg::CSR_OP_WRITE) || (rs1_field != 5'd0));

endmodule

// ==== csr_execute.sv ====
`timescale 1ns/10ps

module csr_execute (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       csr_en_i,
  input  logic                       csr_we_i,
  input  logic                       mret_i,
  input  logic                       illegal_i,
  input  riscv_csr_pkg::csr_op_t     csr_op_i,
  input  riscv_csr_pkg::csr_addr_t   csr_addr_i,
  input  riscv_csr_pkg::xlen_t       csr_wdata_i,
  input  riscv_csr_pkg::xlen_t       pc_i,
  input  riscv_csr_pkg::xlen_t       illegal_info_i,
  input  logic                       exc_request_i,
  input  riscv_csr_pkg::xlen_t       exc_cause_i,
  input  riscv_csr_pkg::xlen_t       exc_info_i,
  input  logic                       tmr_we_i,
  input  csr_platform_pkg::tmr_addr_t tmr_addr_i,
  input  riscv_csr_pkg::xlen_t       tmr_wdata_i,
  output riscv_csr_pkg::xlen_t       csr_rdata_o,
  output riscv_csr_pkg::xlen_t       mtvec_o,
  output riscv_csr_pkg::xlen_t       mepc_o,
  output riscv_csr_pkg::xlen_t       tmr_rdata_o,
  output logic                       trap_take_o,
  output logic                       ret_take_o
);

  // CSR state
  riscv_csr_pkg::xlen_t mstatus_q, mstatus_d;
  riscv_csr_pkg::xlen_t mtvec_q, mtvec_d;
  riscv_csr_pkg::xlen_t mip_q, mip_d;
  riscv_csr_pkg::xlen_t mie_q, mie_d;
  riscv_csr_pkg::xlen_t mscratch_q, mscratch_d;
  riscv_csr_pkg::xlen_t mepc_q, mepc_d;
  riscv_csr_pkg::xlen_t mcause_q, mcause_d;
  riscv_csr_pkg::xlen_t mtval_q, mtval_d;
  csr_platform_pkg::timer_t mtime_q, mtime_d;
  csr_platform_pkg::timer_t mtimecmp_q, mtimecmp_d;

  riscv_csr_pkg::xlen_t old_val;   // Value before the access
  riscv_csr_pkg::xlen_t new_val;   // Value after RMW, unmasked
  logic wr_en;
  logic exc_trap;                  // Synchronous exception
  logic tmr_int;                   // Timer interrupt ready to take
  logic trap_take;
  logic ret_take;

  ////////////////////////////////////////////////////////////////////////////
  // Read and modify
  ////////////////////////////////////////////////////////////////////////////
  always_comb begin : csr_read
    case (csr_addr_i)
      riscv_csr_pkg::CSR_MSTATUS:  old_val = mstatus_q;
      riscv_csr_pkg::CSR_MTVEC:    old_val = mtvec_q;
      riscv_csr_pkg::CSR_MIP:      old_val = mip_q;
      riscv_csr_pkg::CSR_MIE:      old_val = mie_q;
      riscv_csr_pkg::CSR_MSCRATCH: old_val = mscratch_q;
      riscv_csr_pkg::CSR_MEPC:     old_val = mepc_q;
      riscv_csr_pkg::CSR_MCAUSE:   old_val = mcause_q;
      riscv_csr_pkg::CSR_MTVAL:    old_val = mtval_q;
      default:                     old_val = '0;
    endcase
  end

  assign csr_rdata_o = old_val;

  always_comb begin : csr_modify
    case (csr_op_i)
      riscv_csr_pkg::CSR_OP_WRITE: new_val = csr_wdata_i;
      riscv_csr_pkg::CSR_OP_SET:   new_val = old_val | csr_wdata_i;
      riscv_csr_pkg::CSR_OP_CLEAR: new_val = old_val & ~csr_wdata_i;
      default:                     new_val = old_val;
    endcase
  end

  // Trap decision, exceptions first
  assign exc_trap  = illegal_i | exc_request_i;
  assign tmr_int   = mip_q[riscv_csr_pkg::MIP_MTIP_BIT] &
                     mie_q[riscv_csr_pkg::MIE_MTIE_BIT] &
                     mstatus_q[riscv_csr_pkg::MSTATUS_MIE_BIT];
  assign trap_take = exc_trap | tmr_int;
  assign ret_take  = mret_i & ~trap_take;
  assign wr_en     = csr_en_i & csr_we_i & ~trap_take;  // Trapped instr does not commit

  ////////////////////////////////////////////////////////////////////////////
  // Next state
  ////////////////////////////////////////////////////////////////////////////
  always_comb begin : csr_next
    mstatus_d  = mstatus_q;
    mtvec_d    = mtvec_q;
    mip_d      = mip_q;
    mie_d      = mie_q;
    mscratch_d = mscratch_q;
    mepc_d     = mepc_q;
    mcause_d   = mcause_q;
    mtval_d    = mtval_q;
    mtime_d    = mtime_q + 64'd1;   // Free running
    mtimecmp_d = mtimecmp_q;

    if (wr_en) begin
      case (csr_addr_i)
        riscv_csr_pkg::CSR_MSTATUS:  mstatus_d = new_val & csr_platform_pkg::MSTATUS_WMASK;
        riscv_csr_pkg::CSR_MTVEC:    mtvec_d = {new_val[31:2], 2'b00};  // Direct mode only
        riscv_csr_pkg::CSR_MIP:      mip_d = new_val & csr_platform_pkg::MIP_WMASK;
        riscv_csr_pkg::CSR_MIE:      mie_d = new_val & csr_platform_pkg::MIE_WMASK;
        riscv_csr_pkg::CSR_MSCRATCH: mscratch_d = new_val;
        riscv_csr_pkg::CSR_MEPC:     mepc_d = {new_val[31:2], 2'b00};
        riscv_csr_pkg::CSR_MCAUSE:   mcause_d = new_val;
        riscv_csr_pkg::CSR_MTVAL:    mtval_d = new_val;
        default: ;
      endcase
    end

    // Compare only when the interrupt could be taken
    if (mstatus_q[riscv_csr_pkg::MSTATUS_MIE_BIT] && mie_q[riscv_csr_pkg::MIE_MTIE_BIT] &&
        (mtime_q >= mtimecmp_q)) begin
      mip_d[riscv_csr_pkg::MIP_MTIP_BIT] = 1'b1;
    end

    // Timer bus writes
    if (tmr_we_i) begin
      case (tmr_addr_i)
        csr_platform_pkg::MTIME_ADDR_LO: mtime_d = {mtime_q[63:32], tmr_wdata_i};
        csr_platform_pkg::MTIME_ADDR_HI: mtime_d = {tmr_wdata_i, mtime_q[31:0]};
        csr_platform_pkg::MTIMECMP_ADDR_LO: begin
          mtimecmp_d = {mtimecmp_q[63:32], tmr_wdata_i};
          mip_d[riscv_csr_pkg::MIP_MTIP_BIT] = 1'b0;  // Ack of pending timer
        end
        csr_platform_pkg::MTIMECMP_ADDR_HI: begin
          mtimecmp_d = {tmr_wdata_i, mtimecmp_q[31:0]};
          mip_d[riscv_csr_pkg::MIP_MTIP_BIT] = 1'b0;
        end
        default: ;
      endcase
    end

    // Trap entry and return
    if (trap_take) begin
      mepc_d = pc_i;
      mstatus_d[riscv_csr_pkg::MSTATUS_MPIE_BIT] = mstatus_q[riscv_csr_pkg::MSTATUS_MIE_BIT];
      mstatus_d[riscv_csr_pkg::MSTATUS_MIE_BIT]  = 1'b0;  // No nested traps
      if (illegal_i) begin
        mcause_d = riscv_csr_pkg::CAUSE_ILLEGAL_INSTR;
        mtval_d  = illegal_info_i;   // Faulting instruction
      end else if (exc_request_i) begin
        mcause_d = exc_cause_i;
        mtval_d  = exc_info_i;
      end else begin
        mcause_d = riscv_csr_pkg::CAUSE_M_TIMER_INT;
        mtval_d  = '0;
      end
    end else if (ret_take) begin
      mstatus_d[riscv_csr_pkg::MSTATUS_MIE_BIT]  = mstatus_q[riscv_csr_pkg::MSTATUS_MPIE_BIT];
      mstatus_d[riscv_csr_pkg::MSTATUS_MPIE_BIT] = 1'b1;
    end
  end

  always_ff @(posedge clk) begin : csr_regs
    if (rst) begin
      mstatus_q  <= '0;
      mtvec_q    <= csr_platform_pkg::RESET_MTVEC;
      mip_q      <= '0;
      mie_q      <= '0;
      mscratch_q <= '0;
      mepc_q     <= '0;
      mcause_q   <= '0;
      mtval_q    <= '0;
      mtime_q    <= '0;
      mtimecmp_q <= '0;
    end else begin
      mstatus_q  <= mstatus_d;
      mtvec_q    <= mtvec_d;
      mip_q      <= mip_d;
      mie_q      <= mie_d;
      mscratch_q <= mscratch_d;
      mepc_q     <= mepc_d;
      mcause_q   <= mcause_d;
      mtval_q    <= mtval_d;
      mtime_q    <= mtime_d;
      mtimecmp_q <= mtimecmp_d;
    end
  end

  // Timer bus read, straight from the registers
  always_comb begin : tmr_read
    case (tmr_addr_i)
      csr_platform_pkg::MTIME_ADDR_LO:    tmr_rdata_o = mtime_q[31:0];
      csr_platform_pkg::MTIME_ADDR_HI:    tmr_rdata_o = mtime_q[63:32];
      csr_platform_pkg::MTIMECMP_ADDR_LO: tmr_rdata_o = mtimecmp_q[31:0];
      csr_platform_pkg::MTIMECMP_ADDR_HI: tmr_rdata_o = mtimecmp_q[63:32];
      default:                            tmr_rdata_o = '0;
    endcase
  end

  assign mtvec_o     = mtvec_q;
  assign mepc_o      = mepc_q;
  assign trap_take_o = trap_take;
  assign ret_take_o  = ret_take;

endmodule

// ==== csr_result.sv ====
`timescale 1ns/10ps

module csr_result (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 csr_en_i,     // Already gated by the trap
  input  riscv_csr_pkg::xlen_t csr_rdata_i,
  input  logic                 trap_take_i,
  input  logic                 ret_take_i,
  input  riscv_csr_pkg::xlen_t mtvec_i,
  input  riscv_csr_pkg::xlen_t mepc_i,
  output logic                 rd_we_o,
  output logic                 redirect_o,
  output riscv_csr_pkg::xlen_t rd_data_o,
  output riscv_csr_pkg::xlen_t redirect_pc_o
);

  logic redirect_req;   // Trap or return this cycle

  assign redirect_req = trap_take_i | ret_take_i;

  ////////////////////////////////////////////////////////////////////////////
  // Pulses
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin : pulse_regs
    if (rst) begin
      rd_we_o    <= 1'b0;
      redirect_o <= 1'b0;
    end else begin
      rd_we_o    <= csr_en_i;       // One cycle per instruction
      redirect_o <= redirect_req;   // Single cycle level in, single pulse out
    end
  end

  // Payload, only loaded when it matters
  always_ff @(posedge clk) begin : data_regs
    if (csr_en_i) begin
      rd_data_o <= csr_rdata_i;     // Old CSR value to rd
    end
    if (trap_take_i) begin
      redirect_pc_o <= mtvec_i;     // Handler entry
    end else if (ret_take_i) begin
      redirect_pc_o <= mepc_i;      // Back to the interrupted PC
    end
  end

endmodule

// ==== csr_unit_top.sv ====
`timescale 1ns/10ps

module csr_unit_top (
  input  logic                        clk,
  input  logic                        rst,
  input  riscv_csr_pkg::instr_t       instr_i,
  input  logic                        instr_valid_i,
  input  riscv_csr_pkg::xlen_t        rs1_data_i,
  input  riscv_csr_pkg::xlen_t        pc_i,
  input  logic                        exc_request_i,
  input  riscv_csr_pkg::xlen_t        exc_cause_i,
  input  riscv_csr_pkg::xlen_t        exc_info_i,
  input  logic                        tmr_we_i,
  input  csr_platform_pkg::tmr_addr_t tmr_addr_i,
  input  riscv_csr_pkg::xlen_t        tmr_wdata_i,
  output riscv_csr_pkg::xlen_t        tmr_rdata_o,
  output riscv_csr_pkg::xlen_t        rd_data_o,
  output logic                        rd_we_o,
  output logic                        redirect_o,
  output riscv_csr_pkg::xlen_t        redirect_pc_o
);

  // Decode to execute
  logic                     csr_en;
  logic                     csr_we;
  logic                     mret;
  logic                     illegal;
  riscv_csr_pkg::csr_op_t   csr_op;
  riscv_csr_pkg::csr_addr_t csr_addr;
  riscv_csr_pkg::xlen_t     csr_wdata;

  // Execute to result
  riscv_csr_pkg::xlen_t csr_rdata;
  riscv_csr_pkg::xlen_t mtvec;
  riscv_csr_pkg::xlen_t mepc;
  logic                 trap_take;
  logic                 ret_take;
  logic                 wb_en;     // Write-back only if nothing trapped

  assign wb_en = csr_en & ~trap_take;

  csr_decode u_decode (
    .instr_i       (instr_i),
    .instr_valid_i (instr_valid_i),
    .rs1_data_i    (rs1_data_i),
    .csr_en_o      (csr_en),
    .csr_we_o      (csr_we),
    .mret_o        (mret),
    .illegal_o     (illegal),
    .csr_op_o      (csr_op),
    .csr_addr_o    (csr_addr),
    .csr_wdata_o   (csr_wdata)
  );

  csr_execute u_execute (
    .clk            (clk),
    .rst            (rst),
    .csr_en_i       (csr_en),
    .csr_we_i       (csr_we),
    .mret_i         (mret),
    .illegal_i      (illegal),
    .csr_op_i       (csr_op),
    .csr_addr_i     (csr_addr),
    .csr_wdata_i    (csr_wdata),
    .pc_i           (pc_i),
    .illegal_info_i (instr_i),      // Instruction word goes to mtval
    .exc_request_i  (exc_request_i),
    .exc_cause_i    (exc_cause_i),
    .exc_info_i     (exc_info_i),
    .tmr_we_i       (tmr_we_i),
    .tmr_addr_i     (tmr_addr_i),
    .tmr_wdata_i    (tmr_wdata_i),
    .csr_rdata_o    (csr_rdata),
    .mtvec_o        (mtvec),
    .mepc_o         (mepc),
    .tmr_rdata_o    (tmr_rdata_o),
    .trap_take_o    (trap_take),
    .ret_take_o     (ret_take)
  );

  csr_result u_result (
    .clk           (clk),
    .rst           (rst),
    .csr_en_i      (wb_en),
    .csr_rdata_i   (csr_rdata),
    .trap_take_i   (trap_take),
    .ret_take_i    (ret_take),
    .mtvec_i       (mtvec),
    .mepc_i        (mepc),
    .rd_we_o       (rd_we_o),
    .redirect_o    (redirect_o),
    .rd_data_o     (rd_data_o),
    .redirect_pc_o (redirect_pc_o)
  );

endmodule

// ==== csr_unit_chk.sv ====
`timescale 1ns/10ps

module csr_unit_chk (
  input logic clk,
  input logic rst,
  input logic rd_we_i,     // Write-back strobe of the unit
  input logic redirect_i   // Trap or return pulse
);

  int unsigned fail_cnt = 0;

  ////////////////////////////////////////////////////////////////////////////
  // Reset behaviour
  ////////////////////////////////////////////////////////////////////////////
  // Both strobes quiet during reset and the first cycle after
  reset_quiet: assert property (@(posedge clk) rst |=> (!rd_we_i && !redirect_i) [*2])
    else begin
      fail_cnt++;
      $error("rd_we_o or redirect_o active around reset");
    end

  ////////////////////////////////////////////////////////////////////////////
  // Pulse shape
  ////////////////////////////////////////////////////////////////////////////
  redirect_single: assert property (@(posedge clk) disable iff (rst)
                                    redirect_i |=> !redirect_i)
    else begin
      fail_cnt++;
      $error("redirect_o held for two cycles");
    end

  // No write-back in a redirect cycle
  wb_vs_redirect: assert property (@(posedge clk) disable iff (rst) !(rd_we_i && redirect_i))
    else begin
      fail_cnt++;
      $error("rd_we_o high together with redirect_o");
    end

endmodule

bind csr_unit_top csr_unit_chk u_chk (
  .clk        (clk),
  .rst        (rst),
  .rd_we_i    (rd_we_o),
  .redirect_i (redirect_o)
);

// ==== csr_unit_tb.sv ====
`timescale 1ns/10ps

module csr_unit_tb;

  localparam int CLK_PERIOD  = 100;
  localparam int RST_CYCLES  = 16;
  localparam int TEST_CYCLES = 400;   // Reset, reads, RMW sweeps, traps, timer wait

  logic                        clk = 1'b0;
  logic                        rst;
  riscv_csr_pkg::instr_t       instr_i;
  logic                        instr_valid_i;
  riscv_csr_pkg::xlen_t        rs1_data_i;
  riscv_csr_pkg::xlen_t        pc_i;
  logic                        exc_request_i;
  riscv_csr_pkg::xlen_t        exc_cause_i;
  riscv_csr_pkg::xlen_t        exc_info_i;
  logic                        tmr_we_i;
  csr_platform_pkg::tmr_addr_t tmr_addr_i;
  riscv_csr_pkg::xlen_t        tmr_wdata_i;
  riscv_csr_pkg::xlen_t        tmr_rdata_o;
  riscv_csr_pkg::xlen_t        rd_data_o;
  logic                        rd_we_o;
  logic                        redirect_o;
  riscv_csr_pkg::xlen_t        redirect_pc_o;

  integer seed   = 32'h32ce_80f6;
  int     errors = 0;
  int     checks = 0;

  // Reference model state
  riscv_csr_pkg::xlen_t m_mstatus, m_mtvec, m_mie, m_mip;
  riscv_csr_pkg::xlen_t m_mscratch, m_mepc, m_mcause, m_mtval;
  csr_platform_pkg::timer_t m_mtime, m_mtimecmp;

  always #(CLK_PERIOD / 2) clk = ~clk;

  csr_unit_top dut_i (.*);

  ////////////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////////////
  // Timer pair counts every cycle unless the bus writes it
  always @(posedge clk) begin : timer_model
    if (rst) begin
      m_mtime    <= '0;
      m_mtimecmp <= '0;
    end else begin
      m_mtime <= m_mtime + 64'd1;
      if (tmr_we_i) begin
        case (tmr_addr_i)
          csr_platform_pkg::MTIME_ADDR_LO:    m_mtime <= {m_mtime[63:32], tmr_wdata_i};
          csr_platform_pkg::MTIME_ADDR_HI:    m_mtime <= {tmr_wdata_i, m_mtime[31:0]};
          csr_platform_pkg::MTIMECMP_ADDR_LO: m_mtimecmp <= {m_mtimecmp[63:32], tmr_wdata_i};
          csr_platform_pkg::MTIMECMP_ADDR_HI: m_mtimecmp <= {tmr_wdata_i, m_mtimecmp[31:0]};
          default: ;
        endcase
      end
    end
  end

  function automatic riscv_csr_pkg::xlen_t model_read(input riscv_csr_pkg::csr_addr_t a);
    case (a)
      riscv_csr_pkg::CSR_MSTATUS:  return m_mstatus;
      riscv_csr_pkg::CSR_MTVEC:    return m_mtvec;
      riscv_csr_pkg::CSR_MIE:      return m_mie;
      riscv_csr_pkg::CSR_MIP:      return m_mip;
      riscv_csr_pkg::CSR_MSCRATCH: return m_mscratch;
      riscv_csr_pkg::CSR_MEPC:     return m_mepc;
      riscv_csr_pkg::CSR_MCAUSE:   return m_mcause;
      riscv_csr_pkg::CSR_MTVAL:    return m_mtval;
      default:                     return '0;
    endcase
  endfunction

  task automatic model_write(input riscv_csr_pkg::csr_addr_t a, input riscv_csr_pkg::xlen_t v);
    case (a)
      riscv_csr_pkg::CSR_MSTATUS:  m_mstatus = v & csr_platform_pkg::MSTATUS_WMASK;
      riscv_csr_pkg::CSR_MTVEC:    m_mtvec = v & ~32'h3;   // Low bits read as zero
      riscv_csr_pkg::CSR_MIE:      m_mie = v & csr_platform_pkg::MIE_WMASK;
      riscv_csr_pkg::CSR_MIP:      m_mip = v & csr_platform_pkg::MIP_WMASK;
      riscv_csr_pkg::CSR_MSCRATCH: m_mscratch = v;
      riscv_csr_pkg::CSR_MEPC:     m_mepc = v & ~32'h3;
      riscv_csr_pkg::CSR_MCAUSE:   m_mcause = v;
      riscv_csr_pkg::CSR_MTVAL:    m_mtval = v;
      default: ;
    endcase
  endtask

  // Trap entry saves MIE into MPIE
  task automatic model_trap(input riscv_csr_pkg::xlen_t pc, input riscv_csr_pkg::xlen_t cause,
                            input riscv_csr_pkg::xlen_t info);
    m_mepc   = pc;
    m_mcause = cause;
    m_mtval  = info;
    m_mstatus[riscv_csr_pkg::MSTATUS_MPIE_BIT] = m_mstatus[riscv_csr_pkg::MSTATUS_MIE_BIT];
    m_mstatus[riscv_csr_pkg::MSTATUS_MIE_BIT]  = 1'b0;
  endtask

  function automatic riscv_csr_pkg::xlen_t tmr_expect(input csr_platform_pkg::tmr_addr_t a);
    case (a)
      csr_platform_pkg::MTIME_ADDR_LO:    return m_mtime[31:0];
      csr_platform_pkg::MTIME_ADDR_HI:    return m_mtime[63:32];
      csr_platform_pkg::MTIMECMP_ADDR_LO: return m_mtimecmp[31:0];
      csr_platform_pkg::MTIMECMP_ADDR_HI: return m_mtimecmp[63:32];
      default:                            return '0;
    endcase
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Checks and stimulus
  ////////////////////////////////////////////////////////////////////////////
  task automatic check_val(input string name, input riscv_csr_pkg::xlen_t exp,
                           input riscv_csr_pkg::xlen_t act);
    checks++;
    assert (act === exp) else begin
      $display("[ERROR] %0t %s expected %h actual %h", $time, name, exp, act);
      errors++;
    end
  endtask

  // One valid instruction cycle
  task automatic issue(input riscv_csr_pkg::instr_t word, input riscv_csr_pkg::xlen_t rs1);
    @(posedge clk);
    instr_i       <= word;
    instr_valid_i <= 1'b1;
    rs1_data_i    <= rs1;
    @(posedge clk);
    instr_valid_i <= 1'b0;
  endtask

  task automatic csr_op(input logic [2:0] f3, input riscv_csr_pkg::csr_addr_t a,
                        input logic [4:0] src, input riscv_csr_pkg::xlen_t rs1);
    riscv_csr_pkg::xlen_t old_v;
    riscv_csr_pkg::xlen_t wd;
    old_v = model_read(a);
    wd    = f3[2] ? riscv_csr_pkg::xlen_t'(src) : rs1;   // Immediate is zero extended
    if (f3[1:0] == 2'b01) begin
      model_write(a, wd);
    end else if (src != 5'd0) begin
      model_write(a, (f3[1:0] == 2'b10) ? (old_v | wd) : (old_v & ~wd));
    end
    issue({a, src, f3, 5'd1, riscv_csr_pkg::OPCODE_SYSTEM}, rs1);
    @(negedge clk);
    check_val("rd_we_o", 1, rd_we_o);
    check_val("rd_data_o", old_v, rd_data_o);
    check_val("redirect_o", 0, redirect_o);
    @(negedge clk);
    check_val("rd_we_o", 0, rd_we_o);                    // Single pulse
  endtask

  task automatic csr_read(input riscv_csr_pkg::csr_addr_t a);
    csr_op(riscv_csr_pkg::F3_CSRRS, a, 5'd0, $random(seed));  // rs1 data must be ignored
  endtask

  task automatic rmw_sweep(input riscv_csr_pkg::csr_addr_t a);
    logic [4:0] src;
    for (int f = 1; f < 8; f++) begin
      if (f != 4) begin
        src = 5'($random(seed)) | 5'd1;
        csr_op(3'(f), a, src, $random(seed));
        csr_op(3'(f), a, 5'd0, $random(seed));           // Zero source
      end
    end
    csr_read(a);
  endtask

  task automatic expect_redirect(input riscv_csr_pkg::xlen_t target);
    @(negedge clk);
    check_val("redirect_o", 1, redirect_o);
    check_val("redirect_pc_o", target, redirect_pc_o);
    check_val("rd_we_o", 0, rd_we_o);                    // Trapped instr gives no write-back
    @(negedge clk);
    check_val("redirect_o", 0, redirect_o);
  endtask

  // The instruction is valid in the trap cycle and must not commit
  task automatic raise_trap(input logic use_exc, input riscv_csr_pkg::instr_t word,
                            input riscv_csr_pkg::xlen_t pc, input riscv_csr_pkg::xlen_t cause,
                            input riscv_csr_pkg::xlen_t info);
    model_trap(pc, cause, info);
    @(posedge clk);
    pc_i          <= pc;
    instr_i       <= word;
    instr_valid_i <= 1'b1;
    rs1_data_i    <= $random(seed);
    exc_request_i <= use_exc;
    exc_cause_i   <= cause;
    exc_info_i    <= info;
    @(posedge clk);
    instr_valid_i <= 1'b0;
    exc_request_i <= 1'b0;
    expect_redirect(m_mtvec);
  endtask

  task automatic trap_csr_reads();
    csr_read(riscv_csr_pkg::CSR_MEPC);
    csr_read(riscv_csr_pkg::CSR_MCAUSE);
    csr_read(riscv_csr_pkg::CSR_MTVAL);
    csr_read(riscv_csr_pkg::CSR_MSTATUS);
  endtask

  task automatic mret_return();
    riscv_csr_pkg::xlen_t target;
    target = m_mepc;
    m_mstatus[riscv_csr_pkg::MSTATUS_MIE_BIT]  = m_mstatus[riscv_csr_pkg::MSTATUS_MPIE_BIT];
    m_mstatus[riscv_csr_pkg::MSTATUS_MPIE_BIT] = 1'b1;
    issue({riscv_csr_pkg::FUNCT12_MRET, 5'd0, 3'b000, 5'd0, riscv_csr_pkg::OPCODE_SYSTEM}, '0);
    expect_redirect(target);
  endtask

  task automatic tmr_write(input csr_platform_pkg::tmr_addr_t a, input riscv_csr_pkg::xlen_t d);
    @(posedge clk);
    tmr_we_i    <= 1'b1;
    tmr_addr_i  <= a;
    tmr_wdata_i <= d;
    @(posedge clk);
    tmr_we_i <= 1'b0;
    if ((a == csr_platform_pkg::MTIMECMP_ADDR_LO) ||
        (a == csr_platform_pkg::MTIMECMP_ADDR_HI)) begin
      m_mip[riscv_csr_pkg::MIP_MTIP_BIT] = 1'b0;        // Compare write acks MTIP
    end
  endtask

  task automatic tmr_read_check(input csr_platform_pkg::tmr_addr_t a, input string name);
    @(posedge clk);
    tmr_addr_i <= a;
    @(negedge clk);
    check_val(name, tmr_expect(a), tmr_rdata_o);
  endtask

  initial begin : watchdog
    #((TEST_CYCLES + 200) * CLK_PERIOD);
    $display("Timeout: the test sequence did not complete in time");
    $display("RESULT: FAIL");
    $finish;
  end

  initial begin : main
    riscv_csr_pkg::xlen_t     trap_pc;
    csr_platform_pkg::timer_t target;
    int hold;
    int n;
    int total;
    rst = 1'b1;
    instr_i = '0;
    instr_valid_i = 1'b0;
    rs1_data_i = '0;
    pc_i = '0;
    exc_request_i = 1'b0;
    exc_cause_i = '0;
    exc_info_i = '0;
    tmr_we_i = 1'b0;
    tmr_addr_i = '0;
    tmr_wdata_i = '0;
    m_mstatus = '0;
    m_mtvec = csr_platform_pkg::RESET_MTVEC;
    m_mie = '0;
    m_mip = '0;
    m_mscratch = '0;
    m_mepc = '0;
    m_mcause = '0;
    m_mtval = '0;
    repeat (RST_CYCLES) @(posedge clk);
    rst <= 1'b0;

    // Reset values
    csr_read(riscv_csr_pkg::CSR_MSTATUS);
    csr_read(riscv_csr_pkg::CSR_MTVEC);
    csr_read(riscv_csr_pkg::CSR_MIE);
    csr_read(riscv_csr_pkg::CSR_MIP);
    csr_read(riscv_csr_pkg::CSR_MSCRATCH);
    csr_read(riscv_csr_pkg::CSR_MEPC);
    csr_read(riscv_csr_pkg::CSR_MCAUSE);
    csr_read(riscv_csr_pkg::CSR_MTVAL);
    tmr_write(csr_platform_pkg::MTIMECMP_ADDR_HI, 32'hFFFF_FFFF);  // Park the compare

    rmw_sweep(riscv_csr_pkg::CSR_MSCRATCH);
    rmw_sweep(riscv_csr_pkg::CSR_MTVEC);
    rmw_sweep(riscv_csr_pkg::CSR_MIE);
    rmw_sweep(riscv_csr_pkg::CSR_MSTATUS);

    // Illegal funct3, then unknown CSR
    csr_op(riscv_csr_pkg::F3_CSRRSI, riscv_csr_pkg::CSR_MSTATUS, 5'd8, '0);
    raise_trap(1'b0, {riscv_csr_pkg::CSR_MSCRATCH, 5'd3, 3'b100, 5'd1,
               riscv_csr_pkg::OPCODE_SYSTEM}, $random(seed), riscv_csr_pkg::CAUSE_ILLEGAL_INSTR,
               {riscv_csr_pkg::CSR_MSCRATCH, 5'd3, 3'b100, 5'd1, riscv_csr_pkg::OPCODE_SYSTEM});
    trap_csr_reads();
    raise_trap(1'b0, {12'h7C0, 5'd3, riscv_csr_pkg::F3_CSRRW, 5'd1,
               riscv_csr_pkg::OPCODE_SYSTEM}, $random(seed), riscv_csr_pkg::CAUSE_ILLEGAL_INSTR,
               {12'h7C0, 5'd3, riscv_csr_pkg::F3_CSRRW, 5'd1, riscv_csr_pkg::OPCODE_SYSTEM});
    trap_csr_reads();

    // External exception on a CSRRW, then return
    csr_op(riscv_csr_pkg::F3_CSRRSI, riscv_csr_pkg::CSR_MSTATUS, 5'd8, '0);
    raise_trap(1'b1, {riscv_csr_pkg::CSR_MSCRATCH, 5'd3, riscv_csr_pkg::F3_CSRRW, 5'd1,
               riscv_csr_pkg::OPCODE_SYSTEM}, $random(seed), $random(seed), $random(seed));
    trap_csr_reads();
    csr_read(riscv_csr_pkg::CSR_MSCRATCH);               // Trapped CSRRW left it alone
    mret_return();
    csr_read(riscv_csr_pkg::CSR_MSTATUS);

    ////////////////////////////////////////////////////////////////////////////
    // Timer
    ////////////////////////////////////////////////////////////////////////////
    csr_op(riscv_csr_pkg::F3_CSRRCI, riscv_csr_pkg::CSR_MSTATUS, 5'd8, '0);
    tmr_write(csr_platform_pkg::MTIME_ADDR_LO, $random(seed) & 32'h0FFF_FFFF);
    tmr_write(csr_platform_pkg::MTIME_ADDR_HI, $random(seed));
    tmr_read_check(csr_platform_pkg::MTIME_ADDR_LO, "tmr_rdata_o mtime lo");
    tmr_read_check(csr_platform_pkg::MTIME_ADDR_HI, "tmr_rdata_o mtime hi");
    target = m_mtime + 64'd60;                           // Far enough to arm first
    tmr_write(csr_platform_pkg::MTIMECMP_ADDR_LO, target[31:0]);
    tmr_write(csr_platform_pkg::MTIMECMP_ADDR_HI, target[63:32]);
    tmr_read_check(csr_platform_pkg::MTIMECMP_ADDR_LO, "tmr_rdata_o mtimecmp lo");
    tmr_read_check(csr_platform_pkg::MTIMECMP_ADDR_HI, "tmr_rdata_o mtimecmp hi");
    trap_pc = $random(seed) & ~32'h3;
    @(posedge clk);
    pc_i <= trap_pc;
    csr_op(riscv_csr_pkg::F3_CSRRS, riscv_csr_pkg::CSR_MIE, 5'd5, csr_platform_pkg::MIE_WMASK);
    csr_op(riscv_csr_pkg::F3_CSRRSI, riscv_csr_pkg::CSR_MSTATUS, 5'd8, '0);
    hold = -1;                                           // Cycles since compare held
    n = 0;
    while (!redirect_o && (n < 200)) begin
      @(negedge clk);
      n++;
      if (hold >= 0) begin
        hold++;
      end else if (m_mtime >= m_mtimecmp) begin
        hold = 0;
      end
    end
    assert (redirect_o) else begin
      $display("Timer interrupt was not taken within 200 cycles");
      errors++;
    end
    check_val("compare to redirect cycles", 2, hold);   // MTIP then redirect
    m_mip[riscv_csr_pkg::MIP_MTIP_BIT] = 1'b1;
    model_trap(trap_pc, riscv_csr_pkg::CAUSE_M_TIMER_INT, '0);
    check_val("redirect_pc_o", m_mtvec, redirect_pc_o);
    @(negedge clk);
    check_val("redirect_o", 0, redirect_o);
    csr_read(riscv_csr_pkg::CSR_MIP);
    trap_csr_reads();
    tmr_write(csr_platform_pkg::MTIMECMP_ADDR_LO, target[31:0]);
    csr_read(riscv_csr_pkg::CSR_MIP);

    repeat (4) @(posedge clk);
    total = errors + dut_i.u_chk.fail_cnt;
    $display("Checks: %0d  compare errors: %0d  assertion failures: %0d", checks, errors,
             dut_i.u_chk.fail_cnt);
    if (total == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== list.f ====
riscv_csr_pkg.sv
csr_platform_pkg.sv
csr_decode.sv
csr_execute.sv
csr_result.sv
csr_unit_top.sv
csr_unit_chk.sv
csr_unit_tb.sv
